//--- source/xbar_settings.svh
`ifndef XBAR_SETTINGS_SVH
`define XBAR_SETTINGS_SVH

// address map of the interconnect
// anything outside these windows gets DECERR

// on-chip soc memory, 4 KiB
`define SRAM_BASE 32'h0f00_0000
`define SRAM_SIZE 32'h0000_1000

// real-time counter, two 32-bit words
// low word at offset 0, high word at offset 4
`define RTC_BASE 32'h0200_0048
`define RTC_SIZE 32'h0000_0008

// clock cycles per counter tick
`define RTC_DIV 4

// memory depth in 32-bit words
// must cover SRAM_SIZE / 4
`define SRAM_WORDS 1024

`endif

//--- source/axi_pkg.sv
package axi_pkg;

	// field widths
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [7:0]  len_t;
	typedef logic [2:0]  size_t;
	typedef logic [1:0]  burst_t;

	// response codes, EXOKAY unused
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} resp_t;

	// channel payloads with their valid, ready travels alone
	typedef struct packed {
		logic   valid;
		addr_t  addr;
		len_t   len;
		size_t  size;
		burst_t burst;
	} ar_chan_t;

	typedef struct packed {
		logic  valid;
		addr_t addr;
	} aw_chan_t;

	typedef struct packed {
		logic  valid;
		data_t data;
		strb_t strb;
	} w_chan_t;

	typedef struct packed {
		logic  valid;
		data_t data;
		resp_t resp;
		logic  last;
	} r_chan_t;

	typedef struct packed {
		logic  valid;
		resp_t resp;
	} b_chan_t;

endpackage

//--- source/xbar_pkg.sv
package xbar_pkg;

	// decoded destination of a request
	typedef enum logic [1:0] {
		TGT_SRAM,
		TGT_RTC,
		TGT_NONE
	} target_e;

	// crossbar routing states
	// ERR_RESP answers the request inside the crossbar
	typedef enum logic [1:0] {
		IDLE,
		SRAM_XFER,
		RTC_XFER,
		ERR_RESP
	} xbar_state_e;

endpackage

//--- source/addr_decoder.sv
`timescale 1ns/100ps
`include "xbar_settings.svh"

module addr_decoder
	import axi_pkg::*;
	import xbar_pkg::*;
(
	input  addr_t   addr,
	output target_e target,
	output logic    writable
);

	logic hit_sram;
	logic hit_rtc;

	// window compares, upper bound exclusive
	assign hit_sram = (addr >= `SRAM_BASE) && (addr < `SRAM_BASE + `SRAM_SIZE);
	assign hit_rtc  = (addr >= `RTC_BASE) && (addr < `RTC_BASE + `RTC_SIZE);

	always_comb begin
		if (hit_sram) begin
			target = TGT_SRAM;
		end else if (hit_rtc) begin
			target = TGT_RTC;
		end else begin
			target = TGT_NONE;
		end
	end

	// counter is read-only, so only memory takes writes
	assign writable = hit_sram;

endmodule

//--- source/axi_xbar.sv
`timescale 1ns/100ps

module axi_xbar
	import axi_pkg::*;
	import xbar_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	// manager side
	input  ar_chan_t m_ar,
	output logic     m_ar_ready,
	input  aw_chan_t m_aw,
	output logic     m_aw_ready,
	input  w_chan_t  m_w,
	output logic     m_w_ready,
	output r_chan_t  m_r,
	input  logic     m_r_ready,
	output b_chan_t  m_b,
	input  logic     m_b_ready,
	// soc memory side
	output ar_chan_t s_ar,
	input  logic     s_ar_ready,
	output aw_chan_t s_aw,
	input  logic     s_aw_ready,
	output w_chan_t  s_w,
	input  logic     s_w_ready,
	input  r_chan_t  s_r,
	output logic     s_r_ready,
	input  b_chan_t  s_b,
	output logic     s_b_ready,
	// counter side, read only
	output ar_chan_t rtc_ar,
	input  logic     rtc_ar_ready,
	input  r_chan_t  rtc_r,
	output logic     rtc_r_ready,
	// decoder link
	output addr_t    dec_addr,
	input  target_e  dec_target,
	input  logic     dec_writable
);

	xbar_state_e state;
	xbar_state_e state_next;
	logic        is_read;
	logic        req_done;
	resp_t       err_resp;
	logic        addr_hs;
	logic        xfer_done;

	// reads win when both directions are pending
	assign dec_addr = m_ar.valid ? m_ar.addr : m_aw.addr;

	// address phase of the open transaction completes
	assign addr_hs = is_read ? (m_ar.valid & m_ar_ready) : (m_aw.valid & m_aw_ready);

	// last beat or write response taken by the manager
	assign xfer_done = is_read ? (m_r.valid & m_r.last & m_r_ready) : (m_b.valid & m_b_ready);

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (m_ar.valid) begin
					case (dec_target)
						TGT_SRAM: state_next = SRAM_XFER;
						TGT_RTC:  state_next = RTC_XFER;
						default:  state_next = ERR_RESP;
					endcase
				end else if (m_aw.valid && m_w.valid) begin
					// writable implies the memory window
					state_next = dec_writable ? SRAM_XFER : ERR_RESP;
				end
			end
			default: begin
				if (xfer_done) begin
					state_next = IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= IDLE;
			is_read  <= 1'b0;
			req_done <= 1'b0;
		end else begin
			state <= state_next;
			if (state == IDLE) begin
				is_read  <= m_ar.valid;
				req_done <= 1'b0;
			end else if (xfer_done) begin
				req_done <= 1'b0;
			end else if (addr_hs) begin
				req_done <= 1'b1;
			end
		end
	end

	// unmapped gives DECERR, a counter write gives SLVERR
	always_ff @(posedge clk) begin
		if (state == IDLE) begin
			err_resp <= (dec_target == TGT_NONE) ? DECERR : SLVERR;
		end
	end

	// channel steering, unselected outputs stay blank
	always_comb begin
		m_ar_ready  = 1'b0;
		m_aw_ready  = 1'b0;
		m_w_ready   = 1'b0;
		m_r         = '0;
		m_b         = '0;
		s_ar        = '0;
		s_aw        = '0;
		s_w         = '0;
		s_r_ready   = 1'b0;
		s_b_ready   = 1'b0;
		rtc_ar      = '0;
		rtc_r_ready = 1'b0;
		case (state)
			SRAM_XFER: begin
				if (is_read) begin
					s_ar       = m_ar;
					s_ar.valid = m_ar.valid & ~req_done;
					m_ar_ready = s_ar_ready & ~req_done;
					m_r        = s_r;
					s_r_ready  = m_r_ready;
				end else begin
					s_aw       = m_aw;
					s_aw.valid = m_aw.valid & ~req_done;
					s_w        = m_w;
					s_w.valid  = m_w.valid & ~req_done;
					m_aw_ready = s_aw_ready & ~req_done;
					m_w_ready  = s_w_ready & ~req_done;
					m_b        = s_b;
					s_b_ready  = m_b_ready;
				end
			end
			RTC_XFER: begin
				rtc_ar       = m_ar;
				rtc_ar.valid = m_ar.valid & ~req_done;
				m_ar_ready   = rtc_ar_ready & ~req_done;
				m_r          = rtc_r;
				rtc_r_ready  = m_r_ready;
			end
			ERR_RESP: begin
				// take the request, then answer with the error code
				m_ar_ready = is_read & ~req_done;
				m_aw_ready = ~is_read & ~req_done;
				m_w_ready  = ~is_read & ~req_done;
				m_r.valid  = is_read & req_done;
				m_r.resp   = err_resp;
				m_r.last   = 1'b1;
				m_b.valid  = ~is_read & req_done;
				m_b.resp   = err_resp;
			end
			default: begin
			end
		endcase
	end

endmodule

//--- source/rtc_counter.sv
`timescale 1ns/100ps
`include "xbar_settings.svh"

module rtc_counter
	import axi_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  ar_chan_t ar,
	output logic     ar_ready,
	output r_chan_t  r,
	input  logic     r_ready
);

	localparam int DIV_W = $clog2(`RTC_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`RTC_DIV - 1);

	logic [DIV_W-1:0] div_cnt;
	logic [63:0]      ticks;
	data_t            hi_latch;
	data_t            r_data;
	logic             r_valid;

	// prescaler and tick count
	always_ff @(posedge clk) begin
		if (rst) begin
			div_cnt <= '0;
			ticks   <= '0;
		end else if (div_cnt == DIV_LAST) begin
			div_cnt <= '0;
			ticks   <= ticks + 64'd1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// one beat pending at most
	assign ar_ready = ~r_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			r_valid  <= 1'b0;
			hi_latch <= '0;
		end else if (ar.valid && ar_ready) begin
			r_valid <= 1'b1;
			// low word read snapshots the high half
			if (!ar.addr[2]) begin
				r_data   <= ticks[31:0];
				hi_latch <= ticks[63:32];
			end else begin
				r_data <= hi_latch;
			end
		end else if (r_ready) begin
			r_valid <= 1'b0;
		end
	end

	assign r.valid = r_valid;
	assign r.data  = r_data;
	assign r.resp  = OKAY;
	assign r.last  = 1'b1;

endmodule

//--- source/sram_target.sv
`timescale 1ns/100ps
`include "xbar_settings.svh"

module sram_target
	import axi_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  ar_chan_t ar,
	output logic     ar_ready,
	input  aw_chan_t aw,
	output logic     aw_ready,
	input  w_chan_t  w,
	output logic     w_ready,
	output r_chan_t  r,
	input  logic     r_ready,
	output b_chan_t  b,
	input  logic     b_ready
);

	localparam int IDX_W = $clog2(`SRAM_WORDS);

	data_t mem [`SRAM_WORDS];

	logic  rd_active;
	addr_t rd_addr;
	addr_t rd_addr_next;
	len_t  rd_len;
	len_t  beat_cnt;
	data_t r_data;
	logic  b_valid;
	logic  wr_fire;

	assign rd_addr_next = rd_addr + 32'd4;

	// no new burst until the current one ends
	assign ar_ready = ~rd_active;

	// address and data taken together in one cycle
	assign wr_fire  = aw.valid & w.valid & ~b_valid;
	assign aw_ready = wr_fire;
	assign w_ready  = wr_fire;

	// read burst sequencing, word index above the byte offset
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_active <= 1'b0;
			beat_cnt  <= '0;
		end else if (ar.valid && ar_ready) begin
			rd_active <= 1'b1;
			beat_cnt  <= '0;
			rd_len    <= ar.len;
			rd_addr   <= ar.addr;
			r_data    <= mem[ar.addr[IDX_W+1:2]];
		end else if (rd_active && r_ready) begin
			if (beat_cnt == rd_len) begin
				rd_active <= 1'b0;
			end else begin
				beat_cnt <= beat_cnt + 1'b1;
				rd_addr  <= rd_addr_next;
				r_data   <= mem[rd_addr_next[IDX_W+1:2]];
			end
		end
	end

	// bytewise merge under the strobe
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			for (int i = 0; i < 4; i++) begin
				if (w.strb[i]) begin
					mem[aw.addr[IDX_W+1:2]][8*i +: 8] <= w.data[8*i +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			b_valid <= 1'b0;
		end else if (wr_fire) begin
			b_valid <= 1'b1;
		end else if (b_ready) begin
			b_valid <= 1'b0;
		end
	end

	assign r.valid = rd_active;
	assign r.data  = r_data;
	assign r.resp  = OKAY;
	assign r.last  = rd_active && (beat_cnt == rd_len);

	assign b.valid = b_valid;
	assign b.resp  = OKAY;

endmodule

//--- source/soc_top.sv
`timescale 1ns/100ps

module soc_top
	import axi_pkg::*;
	import xbar_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  ar_chan_t m_ar,
	output logic     m_ar_ready,
	input  aw_chan_t m_aw,
	output logic     m_aw_ready,
	input  w_chan_t  m_w,
	output logic     m_w_ready,
	output r_chan_t  m_r,
	input  logic     m_r_ready,
	output b_chan_t  m_b,
	input  logic     m_b_ready
);

	// memory link
	ar_chan_t sram_ar;
	aw_chan_t sram_aw;
	w_chan_t  sram_w;
	r_chan_t  sram_r;
	b_chan_t  sram_b;
	logic     sram_ar_ready;
	logic     sram_aw_ready;
	logic     sram_w_ready;
	logic     sram_r_ready;
	logic     sram_b_ready;

	// counter link
	ar_chan_t rtc_ar;
	r_chan_t  rtc_r;
	logic     rtc_ar_ready;
	logic     rtc_r_ready;

	// decoder link
	addr_t   dec_addr;
	target_e dec_target;
	logic    dec_writable;

	axi_xbar xbar (
		.clk          (clk),
		.rst          (rst),
		.m_ar         (m_ar),
		.m_ar_ready   (m_ar_ready),
		.m_aw         (m_aw),
		.m_aw_ready   (m_aw_ready),
		.m_w          (m_w),
		.m_w_ready    (m_w_ready),
		.m_r          (m_r),
		.m_r_ready    (m_r_ready),
		.m_b          (m_b),
		.m_b_ready    (m_b_ready),
		.s_ar         (sram_ar),
		.s_ar_ready   (sram_ar_ready),
		.s_aw         (sram_aw),
		.s_aw_ready   (sram_aw_ready),
		.s_w          (sram_w),
		.s_w_ready    (sram_w_ready),
		.s_r          (sram_r),
		.s_r_ready    (sram_r_ready),
		.s_b          (sram_b),
		.s_b_ready    (sram_b_ready),
		.rtc_ar       (rtc_ar),
		.rtc_ar_ready (rtc_ar_ready),
		.rtc_r        (rtc_r),
		.rtc_r_ready  (rtc_r_ready),
		.dec_addr     (dec_addr),
		.dec_target   (dec_target),
		.dec_writable (dec_writable)
	);

	addr_decoder decoder (
		.addr     (dec_addr),
		.target   (dec_target),
		.writable (dec_writable)
	);

	rtc_counter rtc (
		.clk      (clk),
		.rst      (rst),
		.ar       (rtc_ar),
		.ar_ready (rtc_ar_ready),
		.r        (rtc_r),
		.r_ready  (rtc_r_ready)
	);

	sram_target sram (
		.clk      (clk),
		.rst      (rst),
		.ar       (sram_ar),
		.ar_ready (sram_ar_ready),
		.aw       (sram_aw),
		.aw_ready (sram_aw_ready),
		.w        (sram_w),
		.w_ready  (sram_w_ready),
		.r        (sram_r),
		.r_ready  (sram_r_ready),
		.b        (sram_b),
		.b_ready  (sram_b_ready)
	);

endmodule

//--- testbench/xbar_props.sv
`timescale 1ns/100ps

module xbar_props
	import axi_pkg::*;
	import xbar_pkg::*;
(
	input logic        clk,
	input logic        rst,
	input xbar_state_e state,
	input logic        is_read,
	input ar_chan_t    m_ar,
	input logic        m_ar_ready,
	input aw_chan_t    m_aw,
	input logic        m_aw_ready,
	input w_chan_t     m_w,
	input logic        m_w_ready,
	input ar_chan_t    s_ar,
	input aw_chan_t    s_aw,
	input w_chan_t     s_w,
	input ar_chan_t    rtc_ar
);

	// manager holds each request until the crossbar takes it
	ar_held: assert property (@(posedge clk) disable iff (rst)
		m_ar.valid && !m_ar_ready |=> m_ar.valid && $stable(m_ar))
		else $error("read address dropped or changed before ready");

	aw_held: assert property (@(posedge clk) disable iff (rst)
		m_aw.valid && !m_aw_ready |=> m_aw.valid && $stable(m_aw))
		else $error("write address dropped or changed before ready");

	w_held: assert property (@(posedge clk) disable iff (rst)
		m_w.valid && !m_w_ready |=> m_w.valid && $stable(m_w))
		else $error("write data dropped or changed before ready");

	// a target request starts only in the first cycle after leaving IDLE
	route_start: assert property (@(posedge clk) disable iff (rst)
		$rose(s_ar.valid || s_aw.valid || s_w.valid || rtc_ar.valid)
		|-> state != IDLE && $past(state) == IDLE)
		else $error("target request raised while idle or in the middle of a transfer");

	// counter is read only
	no_rtc_on_write: assert property (@(posedge clk) disable iff (rst)
		state != IDLE && !is_read |-> !rtc_ar.valid)
		else $error("counter read address issued during a write");

endmodule

//--- testbench/tb_checker.sv
`timescale 1ns/100ps

module tb_checker
	import axi_pkg::*;
(
	input logic    clk,
	input logic    rst,
	input r_chan_t r,
	input logic    r_ready,
	input b_chan_t b,
	input logic    b_ready
);

	// one expected read beat or write response
	typedef struct packed {
		int    test_id;
		logic  is_write;
		resp_t resp;
		data_t data;
		logic  last;
		logic  record_low;
		logic  must_rise;
	} beat_exp_t;

	beat_exp_t exp_q[$];
	int        pass_count = 0;
	int        fail_count = 0;
	bit        test_bad = 1'b0;
	data_t     prev_low;
	r_chan_t   r_prev;
	b_chan_t   b_prev;
	logic      r_stalled;
	logic      b_stalled;

	task automatic push_beat(int test_id, logic is_write, resp_t resp, data_t data,
		logic last, logic record_low, logic must_rise);
		exp_q.push_back(beat_exp_t'{test_id, is_write, resp, data, last, record_low, must_rise});
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	function automatic void mismatch(int test_id, string what, data_t got, data_t want);
		test_bad = 1'b1;
		$display("CHECK FAILED at %0t: test %0d %s, got 0x%h expected 0x%h",
			$time, test_id, what, got, want);
	endfunction

	function automatic void close_test(int test_id, string kind);
		if (test_bad) begin
			fail_count++;
			$display("test %0d %s: fail", test_id, kind);
		end else begin
			pass_count++;
			$display("test %0d %s: pass", test_id, kind);
		end
		test_bad = 1'b0;
	endfunction

	task automatic take_r();
		beat_exp_t e;
		if (exp_q.size() == 0 || exp_q[0].is_write) begin
			$display("error at %0t: read beat arrived while no read was expected", $time);
			fail_count++;
		end else begin
			e = exp_q.pop_front();
			if (r.resp != e.resp) mismatch(e.test_id, "read resp", 32'(r.resp), 32'(e.resp));
			if (r.last != e.last) mismatch(e.test_id, "read last", 32'(r.last), 32'(e.last));
			if (e.must_rise) begin
				if (r.data <= prev_low) mismatch(e.test_id, "counter did not advance", r.data, prev_low);
				prev_low = r.data;
			end else if (e.record_low) begin
				prev_low = r.data;
			end else if (r.data != e.data) begin
				mismatch(e.test_id, "read data", r.data, e.data);
			end
			if (e.last) close_test(e.test_id, "read");
		end
	endtask

	task automatic take_b();
		beat_exp_t e;
		if (exp_q.size() == 0 || !exp_q[0].is_write) begin
			$display("error at %0t: write response arrived while none was expected", $time);
			fail_count++;
		end else begin
			e = exp_q.pop_front();
			if (b.resp != e.resp) mismatch(e.test_id, "write resp", 32'(b.resp), 32'(e.resp));
			close_test(e.test_id, "write");
		end
	endtask

	// values seen here are the ones the edge transfers
	always @(posedge clk) begin
		if (rst) begin
			r_stalled = 1'b0;
			b_stalled = 1'b0;
		end else begin
			// a stalled beat must stay put
			if (r_stalled && r != r_prev) begin
				$display("error at %0t: read beat dropped or changed while stalled", $time);
				test_bad = 1'b1;
			end
			if (b_stalled && b != b_prev) begin
				$display("error at %0t: write response dropped or changed while stalled", $time);
				test_bad = 1'b1;
			end
			if (r.valid && r_ready) take_r();
			if (b.valid && b_ready) take_b();
			r_stalled = r.valid && !r_ready;
			b_stalled = b.valid && !b_ready;
			r_prev = r;
			b_prev = b;
		end
	end

endmodule

//--- testbench/tb_soc_top.sv
`timescale 1ns/100ps
`include "xbar_settings.svh"

module tb_soc_top
	import axi_pkg::*;
();

	localparam int TIMEOUT = 200;

	// how a read row checks its data
	localparam logic [1:0] M_FIXED  = 2'd0;
	localparam logic [1:0] M_SHADOW = 2'd1;
	localparam logic [1:0] M_FIRST  = 2'd2;
	localparam logic [1:0] M_RISING = 2'd3;

	localparam logic  WR   = 1'b1;
	localparam logic  RD   = 1'b0;
	localparam addr_t SRAM = `SRAM_BASE;
	localparam addr_t RTC  = `RTC_BASE;
	localparam addr_t HOLE = 32'h3000_0000;

	typedef struct packed {
		logic       is_write;
		addr_t      addr;
		len_t       len;
		data_t      wdata;
		strb_t      strb;
		logic       rand_data;
		logic [7:0] stall;
		resp_t      exp_resp;
		data_t      exp_data;
		logic [1:0] mode;
	} row_t;

	typedef enum {EV_AR_READY, EV_WRITE_READY, EV_R_BEAT, EV_B_VALID, EV_B_DONE} wait_e;

	logic     clk;
	logic     rst;
	ar_chan_t m_ar;
	logic     m_ar_ready;
	aw_chan_t m_aw;
	logic     m_aw_ready;
	w_chan_t  m_w;
	logic     m_w_ready;
	r_chan_t  m_r;
	logic     m_r_ready;
	b_chan_t  m_b;
	logic     m_b_ready;

	row_t  rows[$];
	data_t shadow [addr_t];
	int    seed;
	bit    timed_out;

	soc_top uut (
		.clk        (clk),
		.rst        (rst),
		.m_ar       (m_ar),
		.m_ar_ready (m_ar_ready),
		.m_aw       (m_aw),
		.m_aw_ready (m_aw_ready),
		.m_w        (m_w),
		.m_w_ready  (m_w_ready),
		.m_r        (m_r),
		.m_r_ready  (m_r_ready),
		.m_b        (m_b),
		.m_b_ready  (m_b_ready)
	);

	tb_checker chk (
		.clk     (clk),
		.rst     (rst),
		.r       (m_r),
		.r_ready (m_r_ready),
		.b       (m_b),
		.b_ready (m_b_ready)
	);

	bind axi_xbar xbar_props props (
		.clk        (clk),
		.rst        (rst),
		.state      (state),
		.is_read    (is_read),
		.m_ar       (m_ar),
		.m_ar_ready (m_ar_ready),
		.m_aw       (m_aw),
		.m_aw_ready (m_aw_ready),
		.m_w        (m_w),
		.m_w_ready  (m_w_ready),
		.s_ar       (s_ar),
		.s_aw       (s_aw),
		.s_w        (s_w),
		.rtc_ar     (rtc_ar)
	);

	always #50 clk = ~clk;

	function automatic void add_row(logic is_write, addr_t addr, len_t len, data_t wdata,
		strb_t strb, logic rand_data, logic [7:0] stall, resp_t exp_resp, data_t exp_data,
		logic [1:0] mode);
		rows.push_back(row_t'{is_write, addr, len, wdata, strb, rand_data, stall,
			exp_resp, exp_data, mode});
	endfunction

	function automatic logic seen(wait_e what);
		case (what)
			EV_AR_READY:    seen = m_ar_ready;
			EV_WRITE_READY: seen = m_aw_ready && m_w_ready;
			EV_R_BEAT:      seen = m_r.valid && m_r_ready;
			EV_B_VALID:     seen = m_b.valid;
			default:        seen = m_b.valid && m_b_ready;
		endcase
	endfunction

	// sampled at the rising edge, before the DUT registers update
	task automatic wait_until(wait_e what, string desc);
		int cnt;
		cnt = 0;
		do begin
			@(posedge clk);
			cnt++;
		end while (!seen(what) && cnt < TIMEOUT);
		if (!seen(what)) begin
			$display("timeout: %s did not happen within %0d cycles", desc, TIMEOUT);
			timed_out = 1'b1;
		end
	endtask

	task automatic do_read(addr_t addr, len_t len, logic [7:0] stall);
		int beats;
		@(negedge clk);
		m_ar = '{valid: 1'b1, addr: addr, len: len, size: 3'd2, burst: 2'b01};
		m_r_ready = 1'b1;
		wait_until(EV_AR_READY, "read address accept");
		@(negedge clk);
		m_ar = '0;
		beats = 0;
		while (!timed_out && beats <= int'(len)) begin
			wait_until(EV_R_BEAT, "read data beat");
			beats++;
			// back-pressure after the first beat
			if (beats == 1 && stall != 0) begin
				@(negedge clk);
				m_r_ready = 1'b0;
				repeat (stall) @(negedge clk);
				m_r_ready = 1'b1;
			end
		end
		@(negedge clk);
		m_r_ready = 1'b0;
	endtask

	task automatic do_write(addr_t addr, data_t data, strb_t strb, logic [7:0] stall);
		@(negedge clk);
		m_aw = '{valid: 1'b1, addr: addr};
		m_w = '{valid: 1'b1, data: data, strb: strb};
		m_b_ready = (stall == 0);
		wait_until(EV_WRITE_READY, "write address and data accept");
		@(negedge clk);
		m_aw = '0;
		m_w = '0;
		if (stall != 0 && !timed_out) begin
			wait_until(EV_B_VALID, "write response");
			repeat (stall) @(negedge clk);
			m_b_ready = 1'b1;
		end
		if (!timed_out) wait_until(EV_B_DONE, "write response accept");
		@(negedge clk);
		m_b_ready = 1'b0;
	endtask

	task automatic run_row(int id, row_t row);
		data_t data;
		data_t want;
		data_t mask;
		addr_t word;
		int    i;
		data = row.rand_data ? data_t'($random(seed)) : row.wdata;
		word = {row.addr[31:2], 2'b00};
		if (row.is_write) begin
			chk.push_beat(id, 1'b1, row.exp_resp, '0, 1'b1, 1'b0, 1'b0);
			// memory model, only writes the target takes
			if (row.exp_resp == OKAY) begin
				mask = {{8{row.strb[3]}}, {8{row.strb[2]}}, {8{row.strb[1]}}, {8{row.strb[0]}}};
				want = shadow.exists(word) ? shadow[word] : '0;
				shadow[word] = (want & ~mask) | (data & mask);
			end
			do_write(row.addr, data, row.strb, row.stall);
		end else begin
			for (i = 0; i <= int'(row.len); i++) begin
				case (row.mode)
					M_FIXED:  want = row.exp_data;
					M_SHADOW: want = shadow.exists(word) ? shadow[word] : '0;
					default:  want = '0;
				endcase
				chk.push_beat(id, 1'b0, row.exp_resp, want, i == int'(row.len),
					row.mode == M_FIRST, row.mode == M_RISING);
				word = word + 32'd4;
			end
			do_read(row.addr, row.len, row.stall);
		end
	endtask

	initial begin
		int i;
		seed = 32'ha21e;
		timed_out = 1'b0;
		clk = 1'b0;
		rst = 1'b1;
		m_ar = '0;
		m_aw = '0;
		m_w = '0;
		m_r_ready = 1'b0;
		m_b_ready = 1'b0;

		// kind, addr, len, wdata, strb, random, stall, resp, first data, data check
		add_row(WR, SRAM + 32'h10, 8'd0, 32'h11223344, 4'hf, 1'b0, 8'd0, OKAY, 32'h0, M_FIXED);
		add_row(WR, SRAM + 32'h10, 8'd0, 32'haabbccdd, 4'h5, 1'b0, 8'd0, OKAY, 32'h0, M_FIXED);
		add_row(RD, SRAM + 32'h10, 8'd0, 32'h0, 4'h0, 1'b0, 8'd0, OKAY, 32'h11bb33dd, M_FIXED);
		add_row(WR, SRAM + 32'h40, 8'd0, 32'h0, 4'hf, 1'b1, 8'd0, OKAY, 32'h0, M_FIXED);
		add_row(WR, SRAM + 32'h44, 8'd0, 32'h0, 4'hf, 1'b1, 8'd0, OKAY, 32'h0, M_FIXED);
		add_row(WR, SRAM + 32'h48, 8'd0, 32'h0, 4'hf, 1'b1, 8'd0, OKAY, 32'h0, M_FIXED);
		add_row(WR, SRAM + 32'h4c, 8'd0, 32'h0, 4'hf, 1'b1, 8'd0, OKAY, 32'h0, M_FIXED);
		add_row(RD, SRAM + 32'h40, 8'd3, 32'h0, 4'h0, 1'b0, 8'd3, OKAY, 32'h0, M_SHADOW);
		add_row(RD, RTC, 8'd0, 32'h0, 4'h0, 1'b0, 8'd0, OKAY, 32'h0, M_FIRST);
		add_row(RD, RTC, 8'd0, 32'h0, 4'h0, 1'b0, 8'd0, OKAY, 32'h0, M_RISING);
		add_row(RD, RTC + 32'h4, 8'd0, 32'h0, 4'h0, 1'b0, 8'd0, OKAY, 32'h0, M_FIXED);
		add_row(WR, RTC, 8'd0, 32'hdeadbeef, 4'hf, 1'b0, 8'd0, SLVERR, 32'h0, M_FIXED);
		add_row(RD, RTC, 8'd0, 32'h0, 4'h0, 1'b0, 8'd0, OKAY, 32'h0, M_RISING);
		add_row(RD, HOLE, 8'd0, 32'h0, 4'h0, 1'b0, 8'd0, DECERR, 32'h0, M_FIXED);
		add_row(WR, HOLE, 8'd0, 32'h12345678, 4'hf, 1'b0, 8'd0, DECERR, 32'h0, M_FIXED);
		add_row(WR, SRAM + 32'h80, 8'd0, 32'h5a5a0f0f, 4'hf, 1'b0, 8'd5, OKAY, 32'h0, M_FIXED);
		add_row(RD, SRAM + 32'h80, 8'd0, 32'h0, 4'h0, 1'b0, 8'd0, OKAY, 32'h0, M_SHADOW);

		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		for (i = 0; i < rows.size(); i++) begin
			if (!timed_out) run_row(i + 1, rows[i]);
		end
		@(negedge clk);

		if (chk.pending() != 0) begin
			$display("error: %0d expected responses never arrived", chk.pending());
		end
		$display("tests passed: %0d, tests failed: %0d", chk.pass_count, chk.fail_count);
		if (timed_out || chk.fail_count != 0 || chk.pending() != 0) begin
			$display("SOME TESTS FAILED");
		end else begin
			$display("ALL TESTS PASSED");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+source
source/axi_pkg.sv
source/xbar_pkg.sv
source/addr_decoder.sv
source/axi_xbar.sv
source/rtc_counter.sv
source/sram_target.sv
source/soc_top.sv
testbench/xbar_props.sv
testbench/tb_checker.sv
testbench/tb_soc_top.sv

//--- Makefile
LOG = sim.log

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_top \
		-f sources.f --Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
